/* Bender.yml */
package:
  name: fpu_csr

sources:
  - include_dirs:
      - design
    files:
      - design/fpu_regs_pkg.sv
      - design/fpu_bus_pkg.sv
      - design/fpu_wb_slave.sv
      - design/fpu_stack_tracker.sv
      - design/fpu_status_word.sv
      - design/fpu_control_word.sv
      - design/fpu_csr_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/fpu_csr_properties.sv
      - tb/fpu_csr_tb.sv

/* compile.f */
+incdir+design
design/fpu_regs_pkg.sv
design/fpu_bus_pkg.sv
design/fpu_wb_slave.sv
design/fpu_stack_tracker.sv
design/fpu_status_word.sv
design/fpu_control_word.sv
design/fpu_csr_top.sv
tb/fpu_csr_properties.sv
tb/fpu_csr_tb.sv

/* design/fpu_bus_pkg.sv */
// Encodings shared between the bus side and the execution side
// Stack operation code and the command register bit layout

`default_nettype none

package fpu_bus_pkg;

    // Stack operation from the execution unit
    typedef enum logic [1:0] {
        STK_NONE = 2'b00,
        STK_PUSH = 2'b01,
        STK_POP  = 2'b10
    } stack_op_e;

    // Command word at the command address
    typedef struct packed {
        logic [13:0] rsvd;   // Ignored
        logic        finit;  // [1] Initialize
        logic        clex;   // [0] Clear exceptions
    } cmd_word_t;

endpackage

`default_nettype wire

/* design/fpu_control_word.sv */
// Control word register and interrupt request
// IRQ rises for any set exception whose mask is clear, unless iem is set

`default_nettype none

`include "fpu_defines.svh"

module fpu_control_word (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    cw_we,
    input  wire logic [`FPU_WB_DW-1:0]   cw_wdata,
    input  wire logic                    finit,
    input  fpu_regs_pkg::exc_flags_t     exc_flags,
    output logic      [`FPU_WB_DW-1:0]   control_word,
    output logic                         irq
);

    fpu_regs_pkg::reg_word_u cw_u;
    logic [5:0]              masks;     // Same order as exc_flags
    logic [5:0]              pending;   // Unmasked flags

    // All 16 bits kept, reserved ones read back as written
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cw_u.cw <= `FPU_CW_INIT;
        end else if (finit) begin
            cw_u.cw <= `FPU_CW_INIT;
        end else if (cw_we) begin
            cw_u.cw <= cw_wdata;
        end
    end

    assign control_word = cw_u;

    // ========================================
    // Interrupt request
    // ========================================
    assign masks   = {cw_u.cw.pm, cw_u.cw.um, cw_u.cw.om,
                      cw_u.cw.zm, cw_u.cw.dm, cw_u.cw.im};
    assign pending = exc_flags & ~masks;
    assign irq     = ~cw_u.cw.iem & (|pending);

endmodule

`default_nettype wire

/* design/fpu_csr_top.sv */
// Top of the FPU register unit: Wishbone slave, stack tracker, status and control words
// Host side on Wishbone, execution unit on loose ports

`default_nettype none

`include "fpu_defines.svh"

module fpu_csr_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    // Wishbone slave
    input  wire logic                    wb_cyc,
    input  wire logic                    wb_stb,
    input  wire logic                    wb_we,
    input  wire logic [`FPU_WB_AW-1:0]   wb_adr,
    input  wire logic [`FPU_WB_DW-1:0]   wb_dat_i,
    output logic                         wb_ack,
    output logic      [`FPU_WB_DW-1:0]   wb_dat_o,
    // Execution unit
    input  wire logic                    exec_start,
    input  wire logic                    exec_done,
    input  wire logic                    cc_write,
    input  wire logic                    c3,
    input  wire logic                    c2,
    input  wire logic                    c1,
    input  wire logic                    c0,
    input  fpu_regs_pkg::exc_flags_t     exc_in,
    input  fpu_bus_pkg::stack_op_e       stack_op,
    output logic      [`FPU_WB_DW-1:0]   status_word,
    output logic                         irq
);

    logic                     cw_we;
    logic [`FPU_WB_DW-1:0]    cw_wdata;
    logic                     clex;
    logic                     finit;
    logic [`FPU_WB_DW-1:0]    control_word;
    logic [`FPU_WB_DW-1:0]    tag_word;
    logic [2:0]               top;
    logic                     stack_fault;
    fpu_regs_pkg::exc_flags_t exc_flags;

    fpu_wb_slave u_wb_slave (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack),
        .wb_dat_o     (wb_dat_o),
        .status_word  (status_word),
        .control_word (control_word),
        .tag_word     (tag_word),
        .cw_we        (cw_we),
        .cw_wdata     (cw_wdata),
        .clex         (clex),
        .finit        (finit)
    );

    fpu_stack_tracker u_stack_tracker (
        .clk         (clk),
        .reset       (reset),
        .stack_op    (stack_op),
        .finit       (finit),
        .top         (top),
        .tag_word    (tag_word),
        .stack_fault (stack_fault)
    );

    fpu_status_word u_status_word (
        .clk         (clk),
        .reset       (reset),
        .top         (top),
        .c3          (c3),
        .c2          (c2),
        .c1          (c1),
        .c0          (c0),
        .cc_write    (cc_write),
        .exc_in      (exc_in),
        .stack_fault (stack_fault),
        .clex        (clex),
        .finit       (finit),
        .exec_start  (exec_start),
        .exec_done   (exec_done),
        .status_word (status_word)
    );

    // Sticky flags sit in the low six status bits, same order
    assign exc_flags = status_word[5:0];

    fpu_control_word u_control_word (
        .clk          (clk),
        .reset        (reset),
        .cw_we        (cw_we),
        .cw_wdata     (cw_wdata),
        .finit        (finit),
        .exc_flags    (exc_flags),
        .control_word (control_word),
        .irq          (irq)
    );

endmodule

`default_nettype wire

/* design/fpu_defines.svh */
// Bus widths, register map, reset values and stack depth of the FPU register unit
// Included by every RTL file that needs a width or an address

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// ========================================
// Wishbone port
// ========================================
`define FPU_WB_DW 16      // Data width
`define FPU_WB_AW 2       // Word address width

// Word addresses
`define FPU_ADR_SW  2'd0  // Status word, read only
`define FPU_ADR_CW  2'd1  // Control word
`define FPU_ADR_TW  2'd2  // Tag word, read only
`define FPU_ADR_CMD 2'd3  // Command, write only

// ========================================
// Reset and initialize values
// ========================================
`define FPU_CW_INIT  16'h037F  // All exceptions masked, 64-bit precision, round nearest
`define FPU_TW_EMPTY 16'hFFFF  // All slots empty

`define FPU_STACK_DEPTH 8      // Register stack slots

`endif

/* design/fpu_regs_pkg.sv */
// Layouts of the architectural registers: status word, control word and tags
// Referenced by scoped names from the status, control and top level blocks

`default_nettype none

package fpu_regs_pkg;

    // Exception flags, same order as status bits 5..0 and control masks 5..0
    typedef struct packed {
        logic pe;   // Precision
        logic ue;   // Underflow
        logic oe;   // Overflow
        logic ze;   // Zero divide
        logic de;   // Denormal operand
        logic ie;   // Invalid operation
    } exc_flags_t;

    // Status word
    typedef struct packed {
        logic       busy;  // [15]
        logic       c3;    // [14]
        logic [2:0] top;   // [13:11]
        logic       c2;    // [10]
        logic       c1;    // [9]
        logic       c0;    // [8]
        logic       es;    // [7] Summary
        logic       sf;    // [6] Stack fault
        logic       pe;
        logic       ue;
        logic       oe;
        logic       ze;
        logic       de;
        logic       ie;    // [0]
    } status_word_t;

    // Control word
    typedef struct packed {
        logic [2:0] rsvd_hi;  // [15:13]
        logic       ic;       // Infinity control
        logic [1:0] rc;       // Rounding
        logic [1:0] pc;       // Precision
        logic       iem;      // [7] Interrupt enable mask
        logic       rsvd6;
        logic       pm;
        logic       um;
        logic       om;
        logic       zm;
        logic       dm;
        logic       im;       // [0]
    } control_word_t;

    // One bus word, seen as status or control layout
    typedef union packed {
        status_word_t  sw;
        control_word_t cw;
    } reg_word_u;

    // Tag per stack slot
    typedef logic [1:0] tag_t;
    localparam tag_t TAG_VALID = 2'b00;
    localparam tag_t TAG_EMPTY = 2'b11;

endpackage

`default_nettype wire

/* design/fpu_stack_tracker.sv */
// Register stack bookkeeping: top-of-stack pointer and the eight slot tags
// Flags a stack fault on push into a used slot or pop of an empty one

`default_nettype none

`include "fpu_defines.svh"

module fpu_stack_tracker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  fpu_bus_pkg::stack_op_e      stack_op,
    input  wire logic                   finit,
    output logic      [2:0]             top,
    output logic      [`FPU_WB_DW-1:0]  tag_word,
    output logic                        stack_fault
);

    // Slot i sits in tag_word bits 2i+1:2i
    fpu_regs_pkg::tag_t [`FPU_STACK_DEPTH-1:0] tags;
    logic [2:0] top_q;
    logic [2:0] push_slot;   // Slot a push lands in
    logic       do_push;
    logic       do_pop;

    assign push_slot = top_q - 3'd1;   // Wraps modulo 8

    // ========================================
    // Fault detection
    // ========================================
    // Same cycle as the stack_op, fed to the status block as a flag
    always_comb begin
        case (stack_op)
            fpu_bus_pkg::STK_PUSH: stack_fault = (tags[push_slot] != fpu_regs_pkg::TAG_EMPTY);
            fpu_bus_pkg::STK_POP:  stack_fault = (tags[top_q] == fpu_regs_pkg::TAG_EMPTY);
            default:               stack_fault = 1'b0;
        endcase
    end

    // Faulting ops leave pointer and tags alone
    assign do_push = (stack_op == fpu_bus_pkg::STK_PUSH) & ~stack_fault;
    assign do_pop  = (stack_op == fpu_bus_pkg::STK_POP) & ~stack_fault;

    // ========================================
    // Pointer and tags
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top_q <= 3'd0;
            tags  <= `FPU_TW_EMPTY;
        end else if (finit) begin
            top_q <= 3'd0;           // Initialize wins over any stack op
            tags  <= `FPU_TW_EMPTY;
        end else if (do_push) begin
            top_q           <= push_slot;
            tags[push_slot] <= fpu_regs_pkg::TAG_VALID;
        end else if (do_pop) begin
            tags[top_q] <= fpu_regs_pkg::TAG_EMPTY;   // Release, then step up
            top_q       <= top_q + 3'd1;
        end
    end

    assign top      = top_q;
    assign tag_word = tags;

endmodule

`default_nettype wire

/* design/fpu_status_word.sv */
// Status word register: busy, condition codes, sticky exceptions and summary
// Clear exceptions bypasses combinationally so the output drops in the same cycle

`default_nettype none

`include "fpu_defines.svh"

module fpu_status_word (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [2:0]              top,
    // Condition codes
    input  wire logic                    c3,
    input  wire logic                    c2,
    input  wire logic                    c1,
    input  wire logic                    c0,
    input  wire logic                    cc_write,
    // Exceptions
    input  fpu_regs_pkg::exc_flags_t     exc_in,
    input  wire logic                    stack_fault,
    // Commands
    input  wire logic                    clex,
    input  wire logic                    finit,
    // Busy handshake
    input  wire logic                    exec_start,
    input  wire logic                    exec_done,
    output logic      [`FPU_WB_DW-1:0]   status_word
);

    logic                     busy_q;
    logic [3:0]               cc_q;        // {c3, c2, c1, c0}
    fpu_regs_pkg::exc_flags_t exc_q;       // Sticky flags
    logic                     sf_q;
    logic                     clr;
    fpu_regs_pkg::exc_flags_t exc_out;     // After bypass
    logic                     sf_out;
    fpu_regs_pkg::reg_word_u  sw_u;

    assign clr = clex | finit;

    // ========================================
    // Registers
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            cc_q   <= 4'b0000;
            exc_q  <= '0;
            sf_q   <= 1'b0;
        end else begin
            // Done has priority over start
            if (exec_done) begin
                busy_q <= 1'b0;
            end else if (exec_start) begin
                busy_q <= 1'b1;
            end

            if (finit) begin
                cc_q <= 4'b0000;
            end else if (cc_write) begin
                cc_q <= {c3, c2, c1, c0};
            end

            if (clr) begin
                exc_q <= '0;
                sf_q  <= 1'b0;
            end else begin
                exc_q <= exc_q | exc_in | {5'b00000, stack_fault};   // Fault also sets ie
                sf_q  <= sf_q | stack_fault;
            end
        end
    end

    // ========================================
    // Output assembly
    // ========================================
    assign exc_out = clr ? '0 : exc_q;
    assign sf_out  = clr ? 1'b0 : sf_q;

    always_comb begin
        sw_u.sw.busy = busy_q;
        sw_u.sw.c3   = cc_q[3];
        sw_u.sw.top  = top;          // Live from the tracker
        sw_u.sw.c2   = cc_q[2];
        sw_u.sw.c1   = cc_q[1];
        sw_u.sw.c0   = cc_q[0];
        sw_u.sw.es   = |exc_out;     // Summary excludes sf
        sw_u.sw.sf   = sf_out;
        sw_u.sw.pe   = exc_out.pe;
        sw_u.sw.ue   = exc_out.ue;
        sw_u.sw.oe   = exc_out.oe;
        sw_u.sw.ze   = exc_out.ze;
        sw_u.sw.de   = exc_out.de;
        sw_u.sw.ie   = exc_out.ie;
    end

    assign status_word = sw_u;

endmodule

`default_nettype wire

/* design/fpu_wb_slave.sv */
// Wishbone classic slave of the FPU register unit
// Single-cycle ack, write strobes in the ack cycle, read mux by word address

`default_nettype none

`include "fpu_defines.svh"

module fpu_wb_slave (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // Wishbone
    input  wire logic                   wb_cyc,
    input  wire logic                   wb_stb,
    input  wire logic                   wb_we,
    input  wire logic [`FPU_WB_AW-1:0]  wb_adr,
    input  wire logic [`FPU_WB_DW-1:0]  wb_dat_i,
    output logic                        wb_ack,
    output logic      [`FPU_WB_DW-1:0]  wb_dat_o,
    // Register read sources
    input  wire logic [`FPU_WB_DW-1:0]  status_word,
    input  wire logic [`FPU_WB_DW-1:0]  control_word,
    input  wire logic [`FPU_WB_DW-1:0]  tag_word,
    // Write strobes, one cycle
    output logic                        cw_we,
    output logic      [`FPU_WB_DW-1:0]  cw_wdata,
    output logic                        clex,
    output logic                        finit
);

    fpu_bus_pkg::cmd_word_t cmd;
    logic                   wr_cyc;   // Write in its ack cycle
    logic                   cmd_wr;

    // ========================================
    // Ack generation
    // ========================================
    // Ack one cycle after the request, never two in a row
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc & wb_stb & ~wb_ack;
        end
    end

    // ========================================
    // Write decode
    // ========================================
    // Host holds adr/dat/we until ack, so decode straight off the bus
    assign wr_cyc = wb_ack & wb_cyc & wb_stb & wb_we;
    assign cmd_wr = wr_cyc & (wb_adr == `FPU_ADR_CMD);
    assign cmd    = wb_dat_i;   // Reserved bits dropped by the layout

    assign cw_we    = wr_cyc & (wb_adr == `FPU_ADR_CW);
    assign cw_wdata = wb_dat_i;
    assign clex     = cmd_wr & cmd.clex;
    assign finit    = cmd_wr & cmd.finit;
    // Status and tag addresses accept writes without effect

    // ========================================
    // Read data
    // ========================================
    always_comb begin
        wb_dat_o = '0;   // Idle bus reads zero
        if (wb_ack) begin
            case (wb_adr)
                `FPU_ADR_SW: wb_dat_o = status_word;
                `FPU_ADR_CW: wb_dat_o = control_word;
                `FPU_ADR_TW: wb_dat_o = tag_word;
                default:     wb_dat_o = '0;   // Command reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb/fpu_csr_properties.sv */
// Concurrent checks on the Wishbone handshake, the interrupt and the status summary
// Bound into the FPU register unit top

`default_nettype none

`include "fpu_defines.svh"

module fpu_csr_properties (
    input wire logic                   clk,
    input wire logic                   reset,
    input wire logic                   wb_cyc,
    input wire logic                   wb_stb,
    input wire logic                   wb_ack,
    input wire logic                   irq,
    input wire logic [`FPU_WB_DW-1:0]  status_word
);

    // Single-cycle ack
    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high two cycles in a row");

    // Ack only answers a request
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc & wb_stb))
        else $error("wb_ack without a preceding request");

    irq_low_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !irq)
        else $error("irq high right after reset");

    // es summarises the six exception flags
    summary_bit: assert property (@(posedge clk) disable iff (reset)
        status_word[7] == |status_word[5:0])
        else $error("status bit 7 differs from the OR of bits 5 to 0");

endmodule

bind fpu_csr_top fpu_csr_properties u_properties (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .irq         (irq),
    .status_word (status_word)
);

`default_nettype wire

/* tb/fpu_csr_tb.sv */
// Directed testbench of the FPU register unit
// Drives the Wishbone port and the execution-side ports, checks the registers by bus reads

`default_nettype none

`include "fpu_defines.svh"

module fpu_csr_tb;

    logic                     clk;
    logic                     reset;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`FPU_WB_AW-1:0]    wb_adr;
    logic [`FPU_WB_DW-1:0]    wb_dat_i;
    logic                     wb_ack;
    logic [`FPU_WB_DW-1:0]    wb_dat_o;
    logic                     exec_start;
    logic                     exec_done;
    logic                     cc_write;
    logic                     c3;
    logic                     c2;
    logic                     c1;
    logic                     c0;
    fpu_regs_pkg::exc_flags_t exc_in;
    fpu_bus_pkg::stack_op_e   stack_op;
    logic [`FPU_WB_DW-1:0]    status_word;
    logic                     irq;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int seed   = 2329;

    fpu_csr_top UUT (.*);

    // ========================================
    // Clock and timeout
    // ========================================
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit in clock cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("Timeout: the tests did not finish within 2000 clock cycles");
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================
    // Bus and port helpers
    // ========================================
    task automatic compare_word(input string what, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Returns at the drive point of the ack cycle
    task automatic await_ack(input logic [1:0] adr);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        while (!wb_ack && n < 3) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!wb_ack) begin
            $display("No ack within 4 cycles for a bus access to address %0d", adr);
            errors++;
        end
    endtask

    // Bus held through the ack cycle, dropped after the closing edge
    task automatic wb_write(input logic [1:0] adr, input logic [15:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        await_ack(adr);
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [15:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        await_ack(adr);
        data = wb_dat_o;   // Valid while ack is high
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic pulse_exc(input logic [5:0] flags);
        exc_in = flags;
        @(posedge clk);
        #2;
        exc_in = '0;
    endtask

    task automatic step_stack(input fpu_bus_pkg::stack_op_e op);
        stack_op = op;
        @(posedge clk);
        #2;
        stack_op = fpu_bus_pkg::STK_NONE;
    endtask

    task automatic load_codes(input logic [3:0] cc);
        {c3, c2, c1, c0} = cc;
        cc_write = 1'b1;
        @(posedge clk);
        #2;
        cc_write = 1'b0;
    endtask

    // Top field, tag word and fault flags against the model
    task automatic verify_stack(input logic [2:0] exp_top, input logic [15:0] exp_tw,
                                input logic exp_sf);
        logic [15:0] d;
        wb_read(`FPU_ADR_SW, d);
        compare_word("top of stack", d[13:11], exp_top);
        compare_word("stack fault bit", d[6], exp_sf);
        compare_word("invalid operation bit", d[0], exp_sf);
        wb_read(`FPU_ADR_TW, d);
        compare_word("tag word", d, exp_tw);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic reset_values;
        logic [15:0] d;
        wb_read(`FPU_ADR_SW, d);
        compare_word("status word after reset", d, 16'h0000);
        wb_read(`FPU_ADR_CW, d);
        compare_word("control word after reset", d, 16'h037F);
        wb_read(`FPU_ADR_TW, d);
        compare_word("tag word after reset", d, 16'hFFFF);
        compare_word("irq after reset", irq, 1'b0);
    endtask

    task automatic register_access;
        logic [15:0] d;
        logic [15:0] v;
        v = $random(seed);
        wb_write(`FPU_ADR_CW, v);
        wb_read(`FPU_ADR_CW, d);
        compare_word("control word readback", d, v);
        wb_write(`FPU_ADR_SW, 16'hFFFF);   // Read only
        wb_read(`FPU_ADR_SW, d);
        compare_word("status word after write", d, 16'h0000);
        wb_write(`FPU_ADR_TW, 16'h0000);   // Read only
        wb_read(`FPU_ADR_TW, d);
        compare_word("tag word after write", d, 16'hFFFF);
        wb_write(`FPU_ADR_CW, `FPU_CW_INIT);
    endtask

    task automatic exception_flow;
        logic [15:0] d;
        logic [31:0] r;
        logic [5:0]  acc;
        int          i;
        acc = '0;
        for (i = 0; i < 6; i++) begin
            r = $random(seed);
            pulse_exc(r[5:0]);
            acc = acc | r[5:0];   // Sticky flags are the OR of all patterns
            wb_read(`FPU_ADR_SW, d);
            compare_word("sticky flags", d[5:0], acc);
            compare_word("summary bit", d[7], |acc);
            compare_word("status word port flags", status_word[5:0], acc);
            compare_word("irq with all masks set", irq, 1'b0);
        end
        if (acc == 6'd0) begin
            pulse_exc(6'h01);
            acc = 6'h01;
        end
        i = 0;
        while (!acc[i]) i++;   // Lowest set flag
        wb_write(`FPU_ADR_CW, `FPU_CW_INIT & ~(16'h0001 << i));
        compare_word("irq with flag unmasked", irq, 1'b1);
        wb_write(`FPU_ADR_CMD, 16'h0001);   // clex
        compare_word("irq after clex", irq, 1'b0);
        wb_read(`FPU_ADR_SW, d);
        compare_word("flags after clex", d[7:0], 8'h00);
        wb_write(`FPU_ADR_CW, `FPU_CW_INIT);
    endtask

    task automatic busy_and_codes;
        logic [15:0] d;
        logic [31:0] r;
        int          i;
        exec_start = 1'b1;
        @(posedge clk);
        #2;
        exec_start = 1'b0;
        wb_read(`FPU_ADR_SW, d);
        compare_word("busy after start", d[15], 1'b1);
        exec_done = 1'b1;
        @(posedge clk);
        #2;
        exec_done = 1'b0;
        wb_read(`FPU_ADR_SW, d);
        compare_word("busy after done", d[15], 1'b0);
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            load_codes(r[3:0]);
            wb_read(`FPU_ADR_SW, d);
            compare_word("condition codes", {d[14], d[10:8]}, r[3:0]);
        end
    endtask

    task automatic stack_walk;
        logic [2:0]  exp_top;
        logic [15:0] exp_tw;
        int          k;
        exp_top = 3'd0;
        exp_tw  = 16'hFFFF;
        for (k = 0; k < 8; k++) begin
            step_stack(fpu_bus_pkg::STK_PUSH);
            exp_top = exp_top - 3'd1;              // Down modulo 8
            exp_tw[2*exp_top +: 2] = 2'b00;        // New top slot valid
            verify_stack(exp_top, exp_tw, 1'b0);
        end
        step_stack(fpu_bus_pkg::STK_PUSH);         // Ninth push lands on a valid slot
        verify_stack(exp_top, exp_tw, 1'b1);
        wb_write(`FPU_ADR_CMD, 16'h0001);
        for (k = 0; k < 8; k++) begin
            step_stack(fpu_bus_pkg::STK_POP);
            exp_tw[2*exp_top +: 2] = 2'b11;
            exp_top = exp_top + 3'd1;
            verify_stack(exp_top, exp_tw, 1'b0);
        end
        step_stack(fpu_bus_pkg::STK_POP);          // Empty stack
        verify_stack(exp_top, exp_tw, 1'b1);
        wb_write(`FPU_ADR_CMD, 16'h0001);
    endtask

    task automatic init_command;
        logic [15:0] d;
        wb_write(`FPU_ADR_CW, `FPU_CW_INIT & ~16'h0001);   // Unmask invalid op
        pulse_exc(6'h01);
        load_codes(4'hF);
        step_stack(fpu_bus_pkg::STK_PUSH);
        compare_word("irq before finit", irq, 1'b1);
        wb_write(`FPU_ADR_CMD, 16'h0002);                  // finit
        wb_read(`FPU_ADR_SW, d);
        compare_word("status word after finit", d, 16'h0000);
        wb_read(`FPU_ADR_CW, d);
        compare_word("control word after finit", d, 16'h037F);
        wb_read(`FPU_ADR_TW, d);
        compare_word("tag word after finit", d, 16'hFFFF);
        compare_word("irq after finit", irq, 1'b0);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_i   = '0;
        exec_start = 1'b0;
        exec_done  = 1'b0;
        cc_write   = 1'b0;
        {c3, c2, c1, c0} = 4'h0;
        exc_in     = '0;
        stack_op   = fpu_bus_pkg::STK_NONE;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        reset_values();
        register_access();
        exception_flow();
        busy_and_codes();
        stack_walk();
        init_command();

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
